/* sim.f */
forthPkg.sv
commitStage.sv
interruptStateMachine.sv
programCounter.sv
interruptUnit.sv
clockGen.sv
interruptChecker.sv
interruptUnit_properties.sv
interruptUnitTb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run; exit status follows the testbench result.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module interruptUnitTb -f sim.f

output=$(./obj_dir/VinterruptUnitTb)
echo "$output"

echo "$output" | grep -q "TEST OK"

/* interruptUnitTb.sv */
`default_nettype none

module interruptUnitTb;
	import forthPkg::*;

	localparam int PHASES = 6;
	localparam int PHASE_LENGTH = 200;
	localparam int WATCHDOG_TIME = PHASES * PHASE_LENGTH * 4 * 100 + 8 * 100;

	logic CLK;
	logic RESET;
	logic COMMIT;
	logic [INSTR_WIDTH-1:0] instr;
	logic INT0;
	logic INT1;
	logic [PC_WIDTH-1:0] pc;
	logic pcValid;
	intState_t intState;
	logic phaseEnd;
	logic [2:0] phaseId;
	logic finalReport;
	int pendingCount;
	int errorCount;
	int checkCount;

	clockGen clocks (.CLK(CLK), .RESET(RESET));

	interruptUnit dut (
		.CLK(CLK),
		.RESET(RESET),
		.COMMIT(COMMIT),
		.instr(instr),
		.INT0(INT0),
		.INT1(INT1),
		.pc(pc),
		.pcValid(pcValid),
		.intState(intState)
	);

	interruptChecker scoreboard (
		.CLK(CLK),
		.RESET(RESET),
		.COMMIT(COMMIT),
		.instr(instr),
		.INT0(INT0),
		.INT1(INT1),
		.pc(pc),
		.pcValid(pcValid),
		.intState(intState),
		.phaseEnd(phaseEnd),
		.phaseId(phaseId),
		.finalReport(finalReport),
		.pendingCount(pendingCount),
		.errorCount(errorCount),
		.checkCount(checkCount)
	);

	function automatic logic chance(input int percent);
		return ($urandom % 100) < 32'(percent);
	endfunction

	function automatic logic [2:0] pickOpcode(input int phase);
		int roll;
		logic [2:0] op;
		roll = int'($urandom % 10);
		op = opNop;
		case (phase)
			1: begin
				if (roll >= 8) op = opDi;
				else if (roll >= 6) op = opEi;
				else if (roll >= 4) op = opJump;
			end
			2, 3: begin
				if (roll >= 7) op = opReti;
				else if (roll == 6) op = opDi;
				else if (roll >= 4) op = opEi;
				else if (roll == 3) op = opJump;
			end
			4: begin
				if (roll >= 7) op = opReti;
				else if (roll == 6) op = opDi;
				else if (roll >= 3) op = opEi;
				else if (roll == 2) op = opJump;
			end
			5: if (roll < 6) op = opReti;
			default: op = 3'($urandom); // includes the unused codes
		endcase
		return op;
	endfunction

	task automatic runPhase(input int phase);
		int issued;
		int int0Pct;
		int int1Pct;
		logic [2:0] op;
		issued = 0;
		int0Pct = 0;
		int1Pct = 0;
		case (phase)
			2: int1Pct = 30;
			3: int0Pct = 25;
			4: begin
				int0Pct = 20;
				int1Pct = 35;
			end
			6: begin
				int0Pct = 15;
				int1Pct = 25;
			end
			default: ;
		endcase
		while (issued < PHASE_LENGTH) begin
			@(negedge CLK);
			op = pickOpcode(phase);
			COMMIT = chance((phase == 6) ? 90 : 75);
			instr = {op, 13'($urandom)};
			INT0 = chance(int0Pct); // random even when not committed
			INT1 = chance(int1Pct);
			if (COMMIT) issued++;
		end
		@(negedge CLK);
		COMMIT = 1'b0;
		while (pendingCount != 0) @(negedge CLK);
		phaseId = 3'(phase);
		phaseEnd = 1'b1;
		@(negedge CLK);
		phaseEnd = 1'b0;
	endtask

	initial begin : stimulus
		int phase;
		COMMIT = 1'b0;
		instr = '0;
		INT0 = 1'b0;
		INT1 = 1'b0;
		phaseEnd = 1'b0;
		phaseId = 3'd0;
		finalReport = 1'b0;
		@(negedge RESET);
		void'($urandom(32'h2712));
		for (phase = 1; phase <= PHASES; phase++) begin
			runPhase(phase);
		end
		finalReport = 1'b1;
		@(negedge CLK);
		finalReport = 1'b0;
		if (checkCount != PHASES * PHASE_LENGTH) begin
			$display("saw %0d pc updates for %0d commits", checkCount, PHASES * PHASE_LENGTH);
		end
		if (dut.ism.props.failCount != 0) begin
			$display("assertions failed %0d times", dut.ism.props.failCount);
		end
		if (errorCount == 0 && checkCount == PHASES * PHASE_LENGTH &&
			dut.ism.props.failCount == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_TIME);
		$display("timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* interruptUnit_properties.sv */
`default_nettype none

module interruptUnit_properties (
	input logic CLK,
	input logic RESET,
	input logic stepValid,
	input logic saveRet0,
	input logic saveRet1,
	input logic stepDone,
	input forthPkg::intState_t intState
);
	import forthPkg::*;

	int failCount; // read by the testbench top

	saveExclusive: assert property (@(posedge CLK) disable iff (RESET)
		!(saveRet0 && saveRet1))
		else begin
			failCount++;
			$error("saveRet0 and saveRet1 high in the same cycle");
		end

	doneFollowsValid: assert property (@(posedge CLK) disable iff (RESET)
		stepDone == $past(stepValid))
		else begin
			failCount++;
			$error("stepDone did not follow stepValid by one cycle");
		end

	// nesting only builds on an int1 handler
	noRunToNested: assert property (@(posedge CLK) disable iff (RESET)
		intState == stRun |=> intState != stRi1_0)
		else begin
			failCount++;
			$error("state went from stRun straight to stRi1_0");
		end

endmodule

bind interruptStateMachine interruptUnit_properties props (
	.CLK(CLK),
	.RESET(RESET),
	.stepValid(stepValid),
	.saveRet0(saveRet0),
	.saveRet1(saveRet1),
	.stepDone(stepDone),
	.intState(intState)
);

`default_nettype wire

/* interruptChecker.sv */
`default_nettype none

module interruptChecker (
	input logic CLK,
	input logic RESET,
	input logic COMMIT,
	input logic [forthPkg::INSTR_WIDTH-1:0] instr,
	input logic INT0,
	input logic INT1,
	input logic [forthPkg::PC_WIDTH-1:0] pc,
	input logic pcValid,
	input forthPkg::intState_t intState,
	input logic phaseEnd,
	input logic [2:0] phaseId,
	input logic finalReport,
	output int pendingCount,
	output int errorCount,
	output int checkCount
);
	import forthPkg::*;

	logic [PC_WIDTH-1:0] expectedPc[$]; // one entry per commit in flight
	logic [PC_WIDTH-1:0] modelPc;
	logic [PC_WIDTH-1:0] modelRet0;
	logic [PC_WIDTH-1:0] modelRet1;
	logic [PC_WIDTH-1:0] wantPc;
	logic [2:0] commitPipe; // commits one, two and three edges back
	intState_t modelState;
	intState_t stateLagged; // state after the commits two edges back
	logic modelEnable;
	int phaseChecks;
	int phaseErrors;
	int testsDone;

	function automatic string phaseName(input logic [2:0] id);
		case (id)
			3'd1: return "sequential";
			3'd2: return "int1 masking";
			3'd3: return "int0 non-maskable";
			3'd4: return "nesting";
			3'd5: return "reti in run";
			default: return "random back-to-back";
		endcase
	endfunction

	task automatic stepModel(input logic [INSTR_WIDTH-1:0] word, input logic r0, input logic r1);
		logic [2:0] op;
		op = word[15:13];
		if (r0 && (modelState == stRun || modelState == stRi1)) begin
			modelRet0 = modelPc; // discarded instr returns here
			modelPc = INT0_VECTOR;
			if (modelState == stRi1) modelState = stRi1_0;
			else modelState = stRi0;
		end else if (r1 && modelEnable && modelState == stRun) begin
			modelRet1 = modelPc;
			modelPc = INT1_VECTOR;
			modelState = stRi1;
		end else if (op == opJump) begin
			modelPc = {3'b000, word[12:0]};
		end else if (op == opReti && modelState == stRi0) begin
			modelPc = modelRet0;
			modelState = stRun;
		end else if (op == opReti && modelState == stRi1) begin
			modelPc = modelRet1;
			modelState = stRun;
		end else if (op == opReti && modelState == stRi1_0) begin
			modelPc = modelRet0;
			modelState = stRi1;
		end else begin
			if (op == opEi) modelEnable = 1'b1;
			if (op == opDi) modelEnable = 1'b0;
			modelPc = modelPc + 16'd1; // nop, ei, di, unknown, reti in run
		end
	endtask

	always @(posedge CLK) begin
		if (RESET) begin
			expectedPc.delete();
			modelPc = '0;
			modelRet0 = '0;
			modelRet1 = '0;
			commitPipe = '0;
			modelState = stRun;
			stateLagged = stRun;
			modelEnable = 1'b0;
			errorCount = 0;
			checkCount = 0;
			phaseChecks = 0;
			phaseErrors = 0;
			testsDone = 0;
		end else begin
			if (pcValid !== commitPipe[2]) begin
				$display("error: pcValid expected 0x%h, got 0x%h", commitPipe[2], pcValid);
				errorCount++;
				phaseErrors++;
			end
			if (pcValid) begin
				if (expectedPc.size() == 0) begin
					$display("pc was updated with no commit waiting for it");
					errorCount++;
					phaseErrors++;
				end else begin
					wantPc = expectedPc.pop_front();
					checkCount++;
					phaseChecks++;
					if (pc !== wantPc) begin
						$display("error: pc expected 0x%h, got 0x%h", wantPc, pc);
						errorCount++;
						phaseErrors++;
					end
					if (intState !== stateLagged) begin
						$display("error: intState expected 0x%h, got 0x%h", stateLagged, intState);
						errorCount++;
						phaseErrors++;
					end
				end
			end
			stateLagged = modelState;
			commitPipe = {commitPipe[1:0], COMMIT};
			if (COMMIT) begin
				stepModel(instr, INT0, INT1);
				expectedPc.push_back(modelPc);
			end
			if (phaseEnd) begin
				testsDone++;
				$display("test %0d %s: %0d checks, %0d errors", phaseId, phaseName(phaseId),
					phaseChecks, phaseErrors);
				phaseChecks = 0;
				phaseErrors = 0;
			end
			if (finalReport) begin
				$display("totals: %0d tests, %0d checks, %0d errors", testsDone, checkCount,
					errorCount);
			end
		end
		pendingCount = expectedPc.size();
	end

endmodule

`default_nettype wire

/* clockGen.sv */
`default_nettype none

module clockGen (
	output logic CLK,
	output logic RESET
);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK; // period 100
	end

	initial begin
		RESET = 1'b1;
		repeat (8) @(posedge CLK);
		@(negedge CLK);
		RESET = 1'b0; // released on a falling edge
	end

endmodule

`default_nettype wire

/* interruptUnit.sv */
`default_nettype none

module interruptUnit (
	input logic CLK,
	input logic RESET,
	input logic COMMIT,
	input logic [forthPkg::INSTR_WIDTH-1:0] instr,
	input logic INT0,
	input logic INT1,
	output logic [forthPkg::PC_WIDTH-1:0] pc,
	output logic pcValid,
	output forthPkg::intState_t intState
);
	import forthPkg::*;

	logic stepValid;
	logic eiCmd;
	logic diCmd;
	logic retiCmd;
	logic jumpCmd;
	logic [PC_WIDTH-1:0] jumpTarget;
	logic req0;
	logic req1;
	pcSel_t pcSel;
	logic saveRet0;
	logic saveRet1;
	logic stepDone;

	commitStage commit (
		.CLK(CLK),
		.RESET(RESET),
		.COMMIT(COMMIT),
		.instr(instr),
		.INT0(INT0),
		.INT1(INT1),
		.stepValid(stepValid),
		.eiCmd(eiCmd),
		.diCmd(diCmd),
		.retiCmd(retiCmd),
		.jumpCmd(jumpCmd),
		.jumpTarget(jumpTarget),
		.req0(req0),
		.req1(req1)
	);

	interruptStateMachine ism (
		.CLK(CLK),
		.RESET(RESET),
		.stepValid(stepValid),
		.eiCmd(eiCmd),
		.diCmd(diCmd),
		.retiCmd(retiCmd),
		.jumpCmd(jumpCmd),
		.req0(req0),
		.req1(req1),
		.pcSel(pcSel),
		.saveRet0(saveRet0),
		.saveRet1(saveRet1),
		.stepDone(stepDone),
		.intState(intState)
	);

	programCounter pcUnit (
		.CLK(CLK),
		.RESET(RESET),
		.stepDone(stepDone),
		.saveRet0(saveRet0),
		.saveRet1(saveRet1),
		.pcSel(pcSel),
		.jumpTarget(jumpTarget),
		.pc(pc),
		.pcValid(pcValid)
	);

endmodule

`default_nettype wire

/* programCounter.sv */
`default_nettype none

module programCounter (
	input logic CLK,
	input logic RESET,
	input logic stepDone,
	input logic saveRet0,
	input logic saveRet1,
	input forthPkg::pcSel_t pcSel,
	input logic [forthPkg::PC_WIDTH-1:0] jumpTarget,
	output logic [forthPkg::PC_WIDTH-1:0] pc,
	output logic pcValid
);
	import forthPkg::*;

	logic [PC_WIDTH-1:0] ret0; // int0 return address
	logic [PC_WIDTH-1:0] ret1; // int1 return address
	logic [PC_WIDTH-1:0] pcPlusOne;
	logic [PC_WIDTH-1:0] pcNext;

	assign pcPlusOne = pc + 1'b1;

	always_comb begin
		case (pcSel)
			pcInc: pcNext = pcPlusOne;
			pcJump: pcNext = jumpTarget;
			pcIntv0: pcNext = INT0_VECTOR;
			pcIntv1: pcNext = INT1_VECTOR;
			pcIntr0: pcNext = ret0;
			pcIntr1: pcNext = ret1;
			default: pcNext = pcPlusOne;
		endcase
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			pc <= '0;
			pcValid <= 1'b0;
		end else begin
			pcValid <= stepDone;
			if (stepDone) begin
				pc <= pcNext;
			end
		end
	end

	// old pc is the address of the instruction the interrupt displaced
	always_ff @(posedge CLK) begin
		if (stepDone && saveRet0) begin
			ret0 <= pc;
		end
		if (stepDone && saveRet1) begin
			ret1 <= pc;
		end
	end

endmodule

`default_nettype wire

/* interruptStateMachine.sv */
`default_nettype none

module interruptStateMachine (
	input logic CLK,
	input logic RESET,
	input logic stepValid,
	input logic eiCmd,
	input logic diCmd,
	input logic retiCmd,
	input logic jumpCmd,
	input logic req0,
	input logic req1,
	output forthPkg::pcSel_t pcSel,
	output logic saveRet0,
	output logic saveRet1,
	output logic stepDone,
	output forthPkg::intState_t intState
);
	import forthPkg::*;

	logic intEnable;
	logic intEnableNext;
	intState_t stateNext;
	pcSel_t pcSelNext;
	logic saveRet0Next;
	logic saveRet1Next;
	logic takeInt0;
	logic takeInt1;

	// nmi is taken from run or on top of an int1 handler, never twice
	assign takeInt0 = req0 && (intState == stRun || intState == stRi1);

	// maskable, run state only, loses to int0
	assign takeInt1 = req1 && intEnable && (intState == stRun) && !takeInt0;

	always_comb begin
		stateNext = intState;
		intEnableNext = intEnable;
		pcSelNext = pcInc;
		saveRet0Next = 1'b0;
		saveRet1Next = 1'b0;

		if (takeInt0) begin
			pcSelNext = pcIntv0; // committed instr is discarded
			saveRet0Next = 1'b1;
			if (intState == stRi1) begin
				stateNext = stRi1_0;
			end else begin
				stateNext = stRi0;
			end
		end else if (takeInt1) begin
			pcSelNext = pcIntv1;
			saveRet1Next = 1'b1;
			stateNext = stRi1;
		end else if (eiCmd) begin
			intEnableNext = 1'b1;
		end else if (diCmd) begin
			intEnableNext = 1'b0;
		end else if (jumpCmd) begin
			pcSelNext = pcJump;
		end else if (retiCmd) begin
			case (intState)
				stRi0: begin
					pcSelNext = pcIntr0;
					stateNext = stRun;
				end
				stRi1: begin
					pcSelNext = pcIntr1;
					stateNext = stRun;
				end
				stRi1_0: begin
					pcSelNext = pcIntr0; // back into the int1 handler
					stateNext = stRi1;
				end
				default: ; // reti outside a handler is a nop
			endcase
		end
	end

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			intState <= stRun;
			intEnable <= 1'b0;
			pcSel <= pcInc;
			saveRet0 <= 1'b0;
			saveRet1 <= 1'b0;
			stepDone <= 1'b0;
		end else begin
			stepDone <= stepValid;
			saveRet0 <= saveRet0Next; // already qualified by stepValid
			saveRet1 <= saveRet1Next;
			if (stepValid) begin
				intState <= stateNext; // next commit sees this at once
				intEnable <= intEnableNext;
				pcSel <= pcSelNext;
			end
		end
	end

endmodule

`default_nettype wire

/* commitStage.sv */
`default_nettype none

module commitStage (
	input logic CLK,
	input logic RESET,
	input logic COMMIT,
	input logic [forthPkg::INSTR_WIDTH-1:0] instr,
	input logic INT0,
	input logic INT1,
	output logic stepValid,
	output logic eiCmd,
	output logic diCmd,
	output logic retiCmd,
	output logic jumpCmd,
	output logic [forthPkg::PC_WIDTH-1:0] jumpTarget,
	output logic req0,
	output logic req1
);
	import forthPkg::*;

	opcode_t opField; // opcode of the incoming word
	opcode_t opReg;
	logic [TARGET_WIDTH-1:0] targetField;
	logic [PC_WIDTH-1:0] targetReg;
	logic intReq0Reg;
	logic intReq1Reg;

	assign opField = decodeOpcode(instr[INSTR_WIDTH-1 -: OPCODE_WIDTH]);
	assign targetField = instr[TARGET_WIDTH-1:0];

	always_ff @(posedge CLK or posedge RESET) begin
		if (RESET) begin
			stepValid <= 1'b0;
			opReg <= opNop;
			intReq0Reg <= 1'b0;
			intReq1Reg <= 1'b0;
		end else begin
			stepValid <= COMMIT; // one cycle per commit
			if (COMMIT) begin
				opReg <= opField;
				intReq0Reg <= INT0; // requests only seen on commits
				intReq1Reg <= INT1;
			end
		end
	end

	// target follows its instruction one stage behind
	always_ff @(posedge CLK) begin
		if (COMMIT) begin
			targetReg <= extendTarget(targetField);
		end
		if (stepValid) begin
			jumpTarget <= targetReg; // still valid when the pc unit loads
		end
	end

	always_comb begin
		eiCmd = 1'b0;
		diCmd = 1'b0;
		retiCmd = 1'b0;
		jumpCmd = 1'b0;
		if (stepValid) begin
			case (opReg)
				opEi: eiCmd = 1'b1;
				opDi: diCmd = 1'b1;
				opReti: retiCmd = 1'b1;
				opJump: jumpCmd = 1'b1;
				default: ; // nop
			endcase
		end
	end

	assign req0 = stepValid & intReq0Reg;
	assign req1 = stepValid & intReq1Reg;

endmodule

`default_nettype wire

/* forthPkg.sv */
`default_nettype none

package forthPkg;

	localparam int PC_WIDTH = 16;
	localparam int INSTR_WIDTH = 16;
	localparam int OPCODE_WIDTH = 3;
	localparam int TARGET_WIDTH = 13; // jump target, zero-extended to PC_WIDTH

	localparam logic [PC_WIDTH-1:0] INT0_VECTOR = 16'h0008;
	localparam logic [PC_WIDTH-1:0] INT1_VECTOR = 16'h0010;

	typedef enum logic [OPCODE_WIDTH-1:0] {
		opNop = 3'd0,
		opJump = 3'd1,
		opEi = 3'd2,
		opDi = 3'd3,
		opReti = 3'd4
	} opcode_t;

	typedef enum logic [1:0] {
		stRun = 2'd0,
		stRi0 = 2'd1,
		stRi1 = 2'd2,
		stRi1_0 = 2'd3 // int0 nested inside int1
	} intState_t;

	typedef enum logic [2:0] {
		pcInc = 3'd0,
		pcJump = 3'd1,
		pcIntv0 = 3'd2,
		pcIntv1 = 3'd3,
		pcIntr0 = 3'd4,
		pcIntr1 = 3'd5
	} pcSel_t;

	// unused encodings 5..7 fall back to nop
	function automatic opcode_t decodeOpcode(input logic [OPCODE_WIDTH-1:0] field);
		opcode_t op;
		case (field)
			opJump: op = opJump;
			opEi: op = opEi;
			opDi: op = opDi;
			opReti: op = opReti;
			default: op = opNop;
		endcase
		return op;
	endfunction

	function automatic logic [PC_WIDTH-1:0] extendTarget(input logic [TARGET_WIDTH-1:0] field);
		logic [PC_WIDTH-1:0] wide;
		wide = '0;
		wide[TARGET_WIDTH-1:0] = field;
		return wide;
	endfunction

endpackage

`default_nettype wire
